//--- include/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// lane count and downstream credits
`define RV_N_LANES     4   // decode lanes, also the upstream credit count
`define RV_OUT_CREDITS 4   // downstream credits held after reset

// major opcodes, instr[6:2]
`define OP_LOAD    5'b00000
`define OP_MISCMEM 5'b00011
`define OP_OPIMM   5'b00100
`define OP_AUIPC   5'b00101
`define OP_STORE   5'b01000
`define OP_OP      5'b01100
`define OP_LUI     5'b01101
`define OP_BRANCH  5'b11000
`define OP_JALR    5'b11001
`define OP_JAL     5'b11011
`define OP_SYSTEM  5'b11100

// funct3 for OP and OP-IMM
`define FUNC_ADD_SUB 3'b000
`define FUNC_SLL     3'b001
`define FUNC_SLT     3'b010
`define FUNC_SLTU    3'b011
`define FUNC_XOR     3'b100
`define FUNC_SRL_SRA 3'b101
`define FUNC_OR      3'b110
`define FUNC_AND     3'b111

// funct3 for conditional branches
`define FUNC_BEQ  3'b000
`define FUNC_BNE  3'b001
`define FUNC_BLT  3'b100
`define FUNC_BGE  3'b101
`define FUNC_BLTU 3'b110
`define FUNC_BGEU 3'b111

// funct7 values that change the alu op
`define FUNC7_MUL_DIV 7'b0000001   // M extension
`define FUNC7_ALT     7'b0100000   // sub, sra

`endif

//--- logic/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

   // plain vector types
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] imm_t;
   typedef logic [5:0]  branch_mask_t;   // beq, bne, blt, bge, bltu, bgeu from bit 0
   typedef logic [2:0]  funct3_t;

   // lane index, at least one bit even for a single lane
   localparam int LANE_PTR_W = (`RV_N_LANES > 1) ? $clog2(`RV_N_LANES) : 1;
   typedef logic [LANE_PTR_W-1:0] lane_ptr_t;

   // one spare bit over what the credit count needs
   localparam int CREDIT_W = $clog2(`RV_OUT_CREDITS + 1) + 1;
   typedef logic [CREDIT_W-1:0] credit_t;

   typedef enum logic [4:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
      ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
      ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
   } alu_op_e;

   typedef enum logic {SRC1_REGVAL1, SRC1_PC} alu_src1_e;
   typedef enum logic [1:0] {SRC2_REGVAL2, SRC2_IMM} alu_src2_e;

   typedef enum logic [2:0] {
      STAGE_FETCH, STAGE_LOAD, STAGE_STORE, STAGE_BRANCH, STAGE_SYSTEM, STAGE_TRAP
   } next_stage_e;

   typedef enum logic [1:0] {REG_IN_ALU, REG_IN_IMM} reg_input_e;

   // everything one lane hands to the collector
   typedef struct packed {
      reg_idx_t     rs1;
      reg_idx_t     rs2;
      reg_idx_t     rd;
      imm_t         imm;
      branch_mask_t branch_mask;
      alu_op_e      alu_op;
      alu_src1_e    alu_src1;
      alu_src2_e    alu_src2;
      next_stage_e  next_stage;
      logic         wb_from_alu;
      logic         wb_from_imm;
      logic         pc_from_alu;
      reg_input_e   reg_input_sel;
      funct3_t      funct3;
      logic         write_reg;
   } decoded_t;

   // round robin step, wraps after the last lane
   function automatic lane_ptr_t next_ptr(input lane_ptr_t ptr);
      if (ptr == lane_ptr_t'(`RV_N_LANES - 1))
         return '0;
      return ptr + lane_ptr_t'(1);
   endfunction

endpackage

`default_nettype wire

//--- logic/lane_if.sv
`default_nettype none

// dispatcher -> lane -> collector, one per lane
interface lane_if;

   logic                      wr;      // one cycle write strobe
   rv_decode_pkg::instr_t     instr;   // raw word, valid with wr
   logic                      full;    // lane holds a result
   rv_decode_pkg::decoded_t   result;  // held while full
   logic                      pop;     // collector took the result

   modport dispatch (
      output wr,
      output instr
   );

   modport lane (
      input  wr,
      input  instr,
      input  pop,
      output full,
      output result
   );

   modport collect (
      input  full,
      input  result,
      output pop
   );

endinterface

`default_nettype wire

//--- logic/instr_dispatch.sv
`default_nettype none

`include "rv_decode_defines.svh"

// spreads accepted words over the lanes in turn
module instr_dispatch (
   input  wire logic                  i_clk,
   input  wire logic                  i_reset,
   input  wire logic                  i_valid,
   input  wire rv_decode_pkg::instr_t i_instr,
   lane_if.dispatch                   lanes [`RV_N_LANES]
);

   rv_decode_pkg::lane_ptr_t wr_ptr;   // next lane to fill

   // pointer moves on every accepted word
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
      end else if (i_valid) begin
         wr_ptr <= rv_decode_pkg::next_ptr(wr_ptr);
      end
   end

   // lane selection has to be static per instance, hence the loop
   for (genvar g = 0; g < `RV_N_LANES; g++) begin : g_wr
      assign lanes[g].wr    = i_valid && (wr_ptr == rv_decode_pkg::lane_ptr_t'(g));
      assign lanes[g].instr = i_instr;   // all lanes see the word, only one writes
   end

   // no full check here
   // upstream credits keep the target lane empty

endmodule

`default_nettype wire

//--- logic/imm_extract.sv
`default_nettype none

`include "rv_decode_defines.svh"

// immediate by format, selected from the major opcode
module imm_extract (
   input  wire rv_decode_pkg::instr_t i_instr,
   output      rv_decode_pkg::imm_t   o_imm
);

   logic [4:0] opcode;
   logic       sgn;   // sign bit, always instr[31]

   assign opcode = i_instr[6:2];
   assign sgn    = i_instr[31];

   always_comb begin
      case (opcode)
         `OP_STORE: begin   // S
            o_imm = {{20{sgn}}, i_instr[31:25], i_instr[11:7]};
         end
         `OP_BRANCH: begin   // B, halfword aligned
            o_imm = {{19{sgn}}, sgn, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
         end
         `OP_LUI, `OP_AUIPC: begin
            o_imm = {i_instr[31:12], 12'h000};   // U, upper 20 bits
         end
         `OP_JAL: begin   // J
            o_imm = {{11{sgn}}, sgn, i_instr[19:12], i_instr[20],
                     i_instr[30:21], 1'b0};
         end
         default: begin
            // I format
            // meaningless for R type but harmless
            o_imm = {{20{sgn}}, i_instr[31:20]};
         end
      endcase
   end

endmodule

`default_nettype wire

//--- logic/decode_lane.sv
`default_nettype none

`include "rv_decode_defines.svh"

// decodes one word and holds the result until the collector pops it
module decode_lane (
   input wire logic i_clk,
   input wire logic i_reset,
   lane_if.lane     lane
);

   rv_decode_pkg::imm_t     imm;
   rv_decode_pkg::decoded_t dec;        // comb decode of lane.instr
   rv_decode_pkg::decoded_t result_q;   // held result
   logic                    full_q;
   logic [4:0]              opcode;
   logic [6:0]              funct7;
   logic                    is_32b;     // low bits 11, everything else traps

   assign opcode = lane.instr[6:2];
   assign funct7 = lane.instr[31:25];
   assign is_32b = (lane.instr[1:0] == 2'b11);

   imm_extract u_imm (
      .i_instr (lane.instr),
      .o_imm   (imm)
   );

   always_comb begin
      // defaults, also the trap case
      dec               = '0;
      dec.rs1           = lane.instr[19:15];
      dec.rs2           = lane.instr[24:20];
      dec.rd            = lane.instr[11:7];
      dec.imm           = imm;
      dec.funct3        = lane.instr[14:12];
      dec.alu_op        = rv_decode_pkg::ALU_ADD;
      dec.alu_src1      = rv_decode_pkg::SRC1_REGVAL1;
      dec.alu_src2      = rv_decode_pkg::SRC2_REGVAL2;
      dec.reg_input_sel = rv_decode_pkg::REG_IN_ALU;
      dec.next_stage    = rv_decode_pkg::STAGE_TRAP;

      if (is_32b) begin
         case (opcode)
            `OP_OP, `OP_OPIMM: begin
               if (opcode == `OP_OPIMM)
                  dec.alu_src2 = rv_decode_pkg::SRC2_IMM;
               if (opcode == `OP_OP && funct7 == `FUNC7_MUL_DIV) begin
                  case (dec.funct3)   // M extension
                     `FUNC_ADD_SUB: dec.alu_op = rv_decode_pkg::ALU_MUL;
                     `FUNC_SLL:     dec.alu_op = rv_decode_pkg::ALU_MULH;
                     `FUNC_SLT:     dec.alu_op = rv_decode_pkg::ALU_MULHSU;
                     `FUNC_SLTU:    dec.alu_op = rv_decode_pkg::ALU_MULHU;
                     `FUNC_XOR:     dec.alu_op = rv_decode_pkg::ALU_DIV;
                     `FUNC_SRL_SRA: dec.alu_op = rv_decode_pkg::ALU_DIVU;
                     `FUNC_OR:      dec.alu_op = rv_decode_pkg::ALU_REM;
                     default:       dec.alu_op = rv_decode_pkg::ALU_REMU;
                  endcase
               end else begin
                  case (dec.funct3)
                     `FUNC_ADD_SUB: begin   // no subi, funct7 is imm there
                        if (opcode == `OP_OP && funct7 == `FUNC7_ALT)
                           dec.alu_op = rv_decode_pkg::ALU_SUB;
                        else
                           dec.alu_op = rv_decode_pkg::ALU_ADD;
                     end
                     `FUNC_SLL:  dec.alu_op = rv_decode_pkg::ALU_SLL;
                     `FUNC_SLT:  dec.alu_op = rv_decode_pkg::ALU_SLT;
                     `FUNC_SLTU: dec.alu_op = rv_decode_pkg::ALU_SLTU;
                     `FUNC_XOR:  dec.alu_op = rv_decode_pkg::ALU_XOR;
                     `FUNC_SRL_SRA: begin   // srai too
                        if (funct7 == `FUNC7_ALT)
                           dec.alu_op = rv_decode_pkg::ALU_SRA;
                        else
                           dec.alu_op = rv_decode_pkg::ALU_SRL;
                     end
                     `FUNC_OR:   dec.alu_op = rv_decode_pkg::ALU_OR;
                     default:    dec.alu_op = rv_decode_pkg::ALU_AND;
                  endcase
               end
               dec.wb_from_alu = 1'b1;   // writeback happens in fetch
               dec.next_stage  = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_LOAD, `OP_STORE: begin   // address = rs1 + imm
               dec.alu_src2   = rv_decode_pkg::SRC2_IMM;
               dec.next_stage = (opcode == `OP_LOAD) ? rv_decode_pkg::STAGE_LOAD
                                                     : rv_decode_pkg::STAGE_STORE;
            end
            `OP_JAL, `OP_JALR: begin
               dec.write_reg   = 1'b1;   // link register
               dec.alu_src1    = (opcode == `OP_JAL) ? rv_decode_pkg::SRC1_PC
                                                     : rv_decode_pkg::SRC1_REGVAL1;
               dec.alu_src2    = rv_decode_pkg::SRC2_IMM;
               dec.pc_from_alu = 1'b1;   // target from alu
               dec.next_stage  = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_BRANCH: begin   // compare on alu, mask picks the condition
               dec.next_stage = rv_decode_pkg::STAGE_BRANCH;
               case (dec.funct3)
                  `FUNC_BEQ:  dec.branch_mask[0] = 1'b1;
                  `FUNC_BNE:  dec.branch_mask[1] = 1'b1;
                  `FUNC_BLT:  dec.branch_mask[2] = 1'b1;
                  `FUNC_BGE:  dec.branch_mask[3] = 1'b1;
                  `FUNC_BLTU: dec.branch_mask[4] = 1'b1;
                  `FUNC_BGEU: dec.branch_mask[5] = 1'b1;
                  default:    dec.branch_mask    = '0;   // 010, 011 reserved
               endcase
            end
            `OP_AUIPC: begin   // pc + imm
               dec.alu_src1    = rv_decode_pkg::SRC1_PC;
               dec.alu_src2    = rv_decode_pkg::SRC2_IMM;
               dec.wb_from_alu = 1'b1;
               dec.next_stage  = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_LUI: begin
               dec.wb_from_imm   = 1'b1;
               dec.reg_input_sel = rv_decode_pkg::REG_IN_IMM;
               dec.next_stage    = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_MISCMEM: dec.next_stage = rv_decode_pkg::STAGE_FETCH;   // fence as nop
            `OP_SYSTEM:  dec.next_stage = rv_decode_pkg::STAGE_SYSTEM;
            default:     dec.next_stage = rv_decode_pkg::STAGE_TRAP;
         endcase
      end
   end

   // full flag, wr and pop never hit the same lane together
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         full_q <= 1'b0;
      end else if (lane.wr) begin
         full_q <= 1'b1;
      end else if (lane.pop) begin
         full_q <= 1'b0;
      end
   end

   always_ff @(posedge i_clk) begin
      if (lane.wr)
         result_q <= dec;
   end

   assign lane.full   = full_q;
   assign lane.result = result_q;

endmodule

`default_nettype wire

//--- logic/decode_collect.sv
`default_nettype none

`include "rv_decode_defines.svh"

// drains lanes in dispatch order while downstream credit lasts
module decode_collect (
   input  wire logic              i_clk,
   input  wire logic              i_reset,
   input  wire logic              i_credit,
   lane_if.collect                lanes [`RV_N_LANES],
   output logic                   o_valid,
   output logic                   o_credit,
   output rv_decode_pkg::decoded_t o_result
);

   rv_decode_pkg::lane_ptr_t rd_ptr;     // oldest lane
   rv_decode_pkg::credit_t   credit_q;   // downstream credits left
   logic [`RV_N_LANES-1:0]   lane_full;
   rv_decode_pkg::decoded_t  lane_result [`RV_N_LANES];
   logic                     do_pop;

   // flatten the interface array so rd_ptr can index it
   for (genvar g = 0; g < `RV_N_LANES; g++) begin : g_rd
      assign lane_full[g]   = lanes[g].full;
      assign lane_result[g] = lanes[g].result;
      assign lanes[g].pop   = do_pop && (rd_ptr == rv_decode_pkg::lane_ptr_t'(g));
   end

   assign do_pop = lane_full[rd_ptr] && (credit_q != '0);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rd_ptr   <= '0;
         credit_q <= rv_decode_pkg::credit_t'(`RV_OUT_CREDITS);
         o_valid  <= 1'b0;
         o_credit <= 1'b0;
      end else begin
         if (do_pop)
            rd_ptr <= rv_decode_pkg::next_ptr(rd_ptr);
         // spend and return may land on the same edge
         credit_q <= credit_q - rv_decode_pkg::credit_t'(do_pop)
                              + rv_decode_pkg::credit_t'(i_credit);
         o_valid  <= do_pop;
         o_credit <= do_pop;   // freed lane goes back upstream
      end
   end

   // payload only, qualified by o_valid
   always_ff @(posedge i_clk) begin
      if (do_pop)
         o_result <= lane_result[rd_ptr];
   end

endmodule

`default_nettype wire

//--- logic/rv_decode_top.sv
`default_nettype none

`include "rv_decode_defines.svh"

// multi lane decode stage, credit flow on both sides
module rv_decode_top (
   input  wire logic                          i_clk,
   input  wire logic                          i_reset,
   input  wire logic                          i_valid,
   input  wire rv_decode_pkg::instr_t         i_instr,
   input  wire logic                          i_credit,
   output logic                               o_valid,
   output logic                               o_credit,
   output rv_decode_pkg::reg_idx_t            o_rs1,
   output rv_decode_pkg::reg_idx_t            o_rs2,
   output rv_decode_pkg::reg_idx_t            o_rd,
   output rv_decode_pkg::imm_t                o_imm,
   output rv_decode_pkg::branch_mask_t        o_branch_mask,
   output rv_decode_pkg::alu_op_e             o_alu_op,
   output rv_decode_pkg::alu_src1_e           o_alu_src1,
   output rv_decode_pkg::alu_src2_e           o_alu_src2,
   output rv_decode_pkg::next_stage_e         o_next_stage,
   output logic                               o_wb_from_alu,
   output logic                               o_wb_from_imm,
   output logic                               o_pc_from_alu,
   output rv_decode_pkg::reg_input_e          o_reg_input_sel,
   output rv_decode_pkg::funct3_t             o_funct3,
   output logic                               o_write_reg
);

   rv_decode_pkg::decoded_t result;

   lane_if lanes [`RV_N_LANES] ();

   instr_dispatch u_dispatch (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (i_valid),
      .i_instr (i_instr),
      .lanes   (lanes)
   );

   for (genvar g = 0; g < `RV_N_LANES; g++) begin : g_lane
      decode_lane u_lane (
         .i_clk   (i_clk),
         .i_reset (i_reset),
         .lane    (lanes[g])
      );
   end

   decode_collect u_collect (
      .i_clk    (i_clk),
      .i_reset  (i_reset),
      .i_credit (i_credit),
      .lanes    (lanes),
      .o_valid  (o_valid),
      .o_credit (o_credit),
      .o_result (result)
   );

   // struct back onto plain ports
   assign o_rs1           = result.rs1;
   assign o_rs2           = result.rs2;
   assign o_rd            = result.rd;
   assign o_imm           = result.imm;
   assign o_branch_mask   = result.branch_mask;
   assign o_alu_op        = result.alu_op;
   assign o_alu_src1      = result.alu_src1;
   assign o_alu_src2      = result.alu_src2;
   assign o_next_stage    = result.next_stage;
   assign o_wb_from_alu   = result.wb_from_alu;
   assign o_wb_from_imm   = result.wb_from_imm;
   assign o_pc_from_alu   = result.pc_from_alu;
   assign o_reg_input_sel = result.reg_input_sel;
   assign o_funct3        = result.funct3;
   assign o_write_reg     = result.write_reg;

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`default_nettype none

// free running clock, 40 ns period
module tb_clock (
   output logic o_clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial o_clk = 1'b0;
   always #20 o_clk = ~o_clk;   // half period
endmodule

`default_nettype wire

//--- verification/rv_decode_assert.sv
`default_nettype none

`include "rv_decode_defines.svh"

// protocol and field checks on the top level ports
module rv_decode_assert (
   input wire logic                          i_clk,
   input wire logic                          i_reset,
   input wire logic                          i_valid,
   input wire logic                          i_credit,
   input wire logic                          o_valid,
   input wire logic                          o_credit,
   input wire rv_decode_pkg::imm_t           o_imm,
   input wire rv_decode_pkg::branch_mask_t   o_branch_mask,
   input wire rv_decode_pkg::alu_src1_e      o_alu_src1,
   input wire rv_decode_pkg::next_stage_e    o_next_stage,
   input wire logic                          o_wb_from_alu,
   input wire logic                          o_wb_from_imm,
   input wire logic                          o_pc_from_alu,
   input wire logic                          o_write_reg
);
   timeunit 1ns;
   timeprecision 100ps;

   int dn_cnt;     // downstream credits as the consumer sees them
   int accepted;   // words taken upstream
   int returned;   // o_credit pulses so far

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         dn_cnt   <= `RV_OUT_CREDITS;
         accepted <= 0;
         returned <= 0;
      end else begin
         dn_cnt   <= dn_cnt - int'(o_valid) + int'(i_credit);
         accepted <= accepted + int'(i_valid);
         returned <= returned + int'(o_credit);
      end
   end

   quiet_after_reset: assert property (@(posedge i_clk) i_reset |=> !o_valid && !o_credit)
      else $error("o_valid or o_credit high right after reset");

   valid_needs_credit: assert property (@(posedge i_clk) disable iff (i_reset)
      o_valid |-> dn_cnt > 0)
      else $error("o_valid without downstream credit");

   credit_bounded: assert property (@(posedge i_clk) disable iff (i_reset)
      o_credit |-> returned < accepted)
      else $error("more credits returned than words accepted");

   upper_imm_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
      o_valid && (o_wb_from_imm || (o_alu_src1 == rv_decode_pkg::SRC1_PC && o_wb_from_alu))
      |-> o_imm[11:0] == 12'h000)
      else $error("lui or auipc immediate has low bits set");

   mask_shape: assert property (@(posedge i_clk) disable iff (i_reset)
      o_valid |-> ((o_next_stage == rv_decode_pkg::STAGE_BRANCH) ? $onehot0(o_branch_mask)
                                                                 : (o_branch_mask == '0)))
      else $error("branch mask malformed");

   trap_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
      o_valid && o_next_stage == rv_decode_pkg::STAGE_TRAP
      |-> !(o_write_reg || o_wb_from_alu || o_wb_from_imm || o_pc_from_alu))
      else $error("trap result with a flag set");
endmodule

bind rv_decode_top rv_decode_assert u_chk (.*);

`default_nettype wire

//--- verification/tb_rv_decode.sv
`default_nettype none

`include "rv_decode_defines.svh"

module tb_rv_decode;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_RANDOM = 300;
   localparam int N_TOTAL  = 48 + N_RANDOM;   // 48 directed alu words first

   logic clk, i_reset, i_valid, i_credit, o_valid, o_credit;
   rv_decode_pkg::instr_t i_instr;
   rv_decode_pkg::reg_idx_t o_rs1, o_rs2, o_rd;
   rv_decode_pkg::imm_t o_imm;
   rv_decode_pkg::branch_mask_t o_branch_mask;
   rv_decode_pkg::alu_op_e o_alu_op;
   rv_decode_pkg::alu_src1_e o_alu_src1;
   rv_decode_pkg::alu_src2_e o_alu_src2;
   rv_decode_pkg::next_stage_e o_next_stage;
   logic o_wb_from_alu, o_wb_from_imm, o_pc_from_alu, o_write_reg;
   rv_decode_pkg::reg_input_e o_reg_input_sel;
   rv_decode_pkg::funct3_t o_funct3;

   integer seed = 48185;
   int errors = 0, sent = 0, back = 0, got = 0, returned = 0, gap = 0;
   rv_decode_pkg::instr_t words [N_TOTAL];
   rv_decode_pkg::decoded_t exp_q [$];
   rv_decode_pkg::decoded_t exp_cur;
   logic [4:0] ops [12] = '{`OP_LOAD, `OP_MISCMEM, `OP_OPIMM, `OP_AUIPC, `OP_STORE, `OP_OP,
                           `OP_LUI, `OP_BRANCH, `OP_JALR, `OP_JAL, `OP_SYSTEM, 5'b01010};
   logic [6:0] f7s [3] = '{7'h00, `FUNC7_ALT, `FUNC7_MUL_DIV};

   tb_clock u_clk (.o_clk(clk));
   rv_decode_top dut0 (.i_clk(clk), .*);

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // expected decode of one word
   function automatic rv_decode_pkg::decoded_t ref_decode(input rv_decode_pkg::instr_t w);
      rv_decode_pkg::decoded_t d;
      rv_decode_pkg::alu_op_e base [8];
      logic [4:0] op;
      logic [2:0] f3;
      base = '{rv_decode_pkg::ALU_ADD, rv_decode_pkg::ALU_SLL, rv_decode_pkg::ALU_SLT,
               rv_decode_pkg::ALU_SLTU, rv_decode_pkg::ALU_XOR, rv_decode_pkg::ALU_SRL,
               rv_decode_pkg::ALU_OR, rv_decode_pkg::ALU_AND};
      op = w[6:2];
      f3 = w[14:12];
      d = '0;   // all flags low, add, regval sources
      d.rs1 = w[19:15];
      d.rs2 = w[24:20];
      d.rd = w[11:7];
      d.funct3 = f3;
      d.next_stage = rv_decode_pkg::STAGE_TRAP;
      d.imm = 32'($signed(w) >>> 20);   // I format
      if (op == `OP_STORE) d.imm = {d.imm[31:5], w[11:7]};
      if (op == `OP_BRANCH) d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      if (op == `OP_LUI || op == `OP_AUIPC) d.imm = {w[31:12], 12'h000};
      if (op == `OP_JAL) d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      if (w[1:0] == 2'b11) begin
         case (op)
            `OP_OP, `OP_OPIMM: begin
               if (op == `OP_OP && w[31:25] == `FUNC7_MUL_DIV)
                  d.alu_op = rv_decode_pkg::alu_op_e'(int'(rv_decode_pkg::ALU_MUL) + int'(f3));
               else if (f3 == 3'd0 && op == `OP_OP && w[31:25] == `FUNC7_ALT)
                  d.alu_op = rv_decode_pkg::ALU_SUB;
               else if (f3 == 3'd5 && w[31:25] == `FUNC7_ALT)
                  d.alu_op = rv_decode_pkg::ALU_SRA;
               else
                  d.alu_op = base[f3];
               if (op == `OP_OPIMM) d.alu_src2 = rv_decode_pkg::SRC2_IMM;
               d.wb_from_alu = 1'b1;
               d.next_stage = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_LOAD, `OP_STORE: begin
               d.alu_src2 = rv_decode_pkg::SRC2_IMM;
               d.next_stage = (op == `OP_LOAD) ? rv_decode_pkg::STAGE_LOAD
                                               : rv_decode_pkg::STAGE_STORE;
            end
            `OP_JAL, `OP_JALR: begin
               d.write_reg = 1'b1;
               d.pc_from_alu = 1'b1;
               d.alu_src2 = rv_decode_pkg::SRC2_IMM;
               if (op == `OP_JAL) d.alu_src1 = rv_decode_pkg::SRC1_PC;
               d.next_stage = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_BRANCH: begin   // 010 and 011 leave the mask empty
               d.next_stage = rv_decode_pkg::STAGE_BRANCH;
               if (f3 < 3'd2) d.branch_mask = 6'(1 << f3);
               else if (f3 > 3'd3) d.branch_mask = 6'(1 << (f3 - 3'd2));
            end
            `OP_AUIPC: begin
               d.alu_src1 = rv_decode_pkg::SRC1_PC;
               d.alu_src2 = rv_decode_pkg::SRC2_IMM;
               d.wb_from_alu = 1'b1;
               d.next_stage = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_LUI: begin
               d.wb_from_imm = 1'b1;
               d.reg_input_sel = rv_decode_pkg::REG_IN_IMM;
               d.next_stage = rv_decode_pkg::STAGE_FETCH;
            end
            `OP_MISCMEM: d.next_stage = rv_decode_pkg::STAGE_FETCH;
            `OP_SYSTEM: d.next_stage = rv_decode_pkg::STAGE_SYSTEM;
            default: d.next_stage = rv_decode_pkg::STAGE_TRAP;
         endcase
      end
      return d;
   endfunction

   task automatic check_field(input string name, input logic [31:0] e, input logic [31:0] a);
      if (e !== a) begin
         errors++;
         $display("Fail %0t %s expected %h got %h", $time, name, e, a);
      end
   endtask

   task automatic check_result(input rv_decode_pkg::decoded_t e);
      check_field("o_rs1", 32'(e.rs1), 32'(o_rs1));
      check_field("o_rs2", 32'(e.rs2), 32'(o_rs2));
      check_field("o_rd", 32'(e.rd), 32'(o_rd));
      check_field("o_imm", e.imm, o_imm);
      check_field("o_branch_mask", 32'(e.branch_mask), 32'(o_branch_mask));
      check_field("o_alu_op", 32'(e.alu_op), 32'(o_alu_op));
      check_field("o_alu_src1", 32'(e.alu_src1), 32'(o_alu_src1));
      check_field("o_alu_src2", 32'(e.alu_src2), 32'(o_alu_src2));
      check_field("o_next_stage", 32'(e.next_stage), 32'(o_next_stage));
      check_field("o_wb_from_alu", 32'(e.wb_from_alu), 32'(o_wb_from_alu));
      check_field("o_wb_from_imm", 32'(e.wb_from_imm), 32'(o_wb_from_imm));
      check_field("o_pc_from_alu", 32'(e.pc_from_alu), 32'(o_pc_from_alu));
      check_field("o_reg_input_sel", 32'(e.reg_input_sel), 32'(o_reg_input_sel));
      check_field("o_funct3", 32'(e.funct3), 32'(o_funct3));
      check_field("o_write_reg", 32'(e.write_reg), 32'(o_write_reg));
   endtask

   // one word per cycle while upstream credit lasts
   task automatic send_word(input rv_decode_pkg::instr_t w);
      while (sent - back >= `RV_N_LANES) begin
         i_valid = 1'b0;
         @(posedge clk) #1;
      end
      i_valid = 1'b1;
      i_instr = w;
      exp_q.push_back(ref_decode(w));
      sent++;
      @(posedge clk) #1;
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (!i_reset && o_valid) begin
         got++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("o_valid came with no instruction outstanding at %0t", $time);
         end else begin
            exp_cur = exp_q.pop_front();
            check_result(exp_cur);
         end
      end
      if (!i_reset && o_credit) back++;
   end

   // downstream credit return with random long gaps
   initial begin
      i_credit = 1'b0;
      wait (i_reset == 1'b0);
      forever begin
         @(posedge clk) #1;
         i_credit = 1'b0;
         if (gap > 0) gap--;
         else if (rand_below(40) == 0) gap = 20 + rand_below(20);
         else if (got > returned && rand_below(2) == 1) begin
            i_credit = 1'b1;
            returned++;
         end
      end
   end

   initial begin
      #(N_TOTAL * 40 * 40 + 1000);
      $display("timeout with %0d of %0d results out, %0d errors", got, N_TOTAL, errors);
      $display("TEST RESULT: FAIL");
      $finish;
   end

   initial begin
      i_reset = 1'b1;
      i_valid = 1'b0;
      i_instr = '0;
      for (int i = 0; i < 48; i++) begin   // every funct7 and funct3 on OP and OP-IMM
         words[i] = $random(seed);
         words[i][6:0] = {(i < 24) ? `OP_OP : `OP_OPIMM, 2'b11};
         words[i][14:12] = 3'(i % 8);
         words[i][31:25] = f7s[(i / 8) % 3];
      end
      for (int i = 48; i < N_TOTAL; i++) begin
         words[i] = $random(seed);
         if (rand_below(14) < 12) begin
            words[i][6:0] = {ops[rand_below(12)], 2'b11};
            if (words[i][6:2] == `OP_OP || words[i][6:2] == `OP_OPIMM)
               words[i][31:25] = f7s[rand_below(3)];
         end else begin
            words[i][1:0] = 2'(rand_below(3));   // compressed
         end
      end
      repeat (4) @(posedge clk);
      #1 i_reset = 1'b0;
      foreach (words[i]) send_word(words[i]);
      i_valid = 1'b0;
      while (got < N_TOTAL) @(posedge clk);
      repeat (20) @(posedge clk);   // catch extra outputs
      if (back != sent) begin   // every drained lane hands its credit back
         errors++;
         $display("%0d credits returned upstream for %0d words sent", back, sent);
      end
      $display("errors %0d, sent %0d, received %0d", errors, sent, got);
      if (errors == 0) $display("TEST RESULT: PASS");
      else $display("TEST RESULT: FAIL");
      $finish;
   end
endmodule

`default_nettype wire

//--- rv_decode.f
+incdir+include
logic/rv_decode_pkg.sv
logic/lane_if.sv
logic/instr_dispatch.sv
logic/imm_extract.sv
logic/decode_lane.sv
logic/decode_collect.sv
logic/rv_decode_top.sv
verification/tb_clock.sv
verification/rv_decode_assert.sv
verification/tb_rv_decode.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_rv_decode -f rv_decode.f -o sim_rv_decode
./obj_dir/sim_rv_decode > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
   exit 1
fi
exit 0
